// ==== Bender.yml ====
package:
  name: rs_polymul

sources:
  - verilog/rs_pkg.sv
  - verilog/gf_mult.sv
  - verilog/polymul_ctrl.sv
  - verilog/epsilon_shifter.sv
  - verilog/syndrome_mac.sv
  - verilog/rs_polymul.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_rs_polymul.sv

// ==== project.f ====
+incdir+test
verilog/rs_pkg.sv
verilog/gf_mult.sv
verilog/polymul_ctrl.sv
verilog/epsilon_shifter.sv
verilog/syndrome_mac.sv
verilog/rs_polymul.sv
test/tb_rs_polymul.sv

// ==== test/polymul_model.svh ====
// Reference model for the RS erasure polynomial multiplier
// GF(2^6) multiply and the epsilon times S product kept to 20 terms

`ifndef POLYMUL_MODEL_SVH
`define POLYMUL_MODEL_SVH

// full carry-less product first and the high bits folded back after
function automatic logic [SYM_W-1:0] field_mul(input logic [SYM_W-1:0] a,
                                               input logic [SYM_W-1:0] b);
   logic [2*SYM_W-2:0] wide;                        // up to x^10 before reduction
   wide = '0;
   for (int i = 0; i < SYM_W; i++) begin
      if (b[i]) begin
         wide = wide ^ ((2*SYM_W-1)'(a) << i);
      end
   end
   // x^(6+n) equals (x + 1) x^n
   for (int n = SYM_W-2; n >= 0; n--) begin
      if (wide[SYM_W+n]) begin
         wide[SYM_W+n] = 1'b0;
         wide = wide ^ ((2*SYM_W-1)'(GF_POLY) << n);
      end
   end
   return wide[SYM_W-1:0];
endfunction

// low 20 coefficients of e(x) S(x)
// e_20 only reaches x^20 and above so it never shows up here
function automatic logic [NUM_SYND-1:0][SYM_W-1:0] trunc_product(
   input logic [NUM_SYND-1:0][SYM_W-1:0] s,
   input logic [NUM_EPS-1:0][SYM_W-1:0]  e
);
   logic [NUM_SYND-1:0][SYM_W-1:0] c;
   c = '0;
   for (int j = 0; j < NUM_SYND; j++) begin
      for (int k = 0; k <= j; k++) begin
         c[j] = c[j] ^ field_mul(e[k], s[j-k]);
      end
   end
   return c;
endfunction

`endif

// ==== test/tb_rs_polymul.sv ====
// Testbench for the RS erasure polynomial multiplier
// Random jobs with and without stalls, restarts and result hold,
// all checked against a software model of the truncated product

module tb_rs_polymul
   import rs_pkg::*;
();

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 16;
   localparam int NUM_RANDOM   = 40;                // enable held high
   localparam int NUM_STALL    = 20;                // random enable
   localparam int NUM_RESTART  = 4;                 // two jobs each
   localparam int TOTAL_JOBS   = NUM_RANDOM + NUM_STALL + 2 + 2*NUM_RESTART;
   localparam int JOB_LIMIT    = 200;               // cycles allowed per job
   localparam int LATENCY      = 21;                // enabled edges, sync to done

   logic                           CLK;
   logic                           RESET;
   logic                           enable;
   logic                           sync;
   logic [NUM_SYND-1:0][SYM_W-1:0] syndrome_in;
   logic [NUM_EPS-1:0][SYM_W-1:0]  epsilon_in;
   logic [NUM_SYND-1:0][SYM_W-1:0] syndrome_out;
   logic                           done;

   int                             errors;
   logic [NUM_SYND-1:0][SYM_W-1:0] last_expect;     // result of last finished job

   `include "polymul_model.svh"

   rs_polymul uut (
      .CLK          (CLK),
      .RESET        (RESET),
      .enable       (enable),
      .sync         (sync),
      .syndrome_in  (syndrome_in),
      .epsilon_in   (epsilon_in),
      .syndrome_out (syndrome_out),
      .done         (done)
   );

   always #(CLK_PERIOD/2) CLK = ~CLK;

   // --------------------
   // stimulus helpers
   // --------------------
   function automatic logic [NUM_SYND-1:0][SYM_W-1:0] rand_synd();
      logic [NUM_SYND-1:0][SYM_W-1:0] v;
      for (int i = 0; i < NUM_SYND; i++) begin
         v[i] = SYM_W'($urandom_range(2**SYM_W-1));
      end
      return v;
   endfunction

   function automatic logic [NUM_EPS-1:0][SYM_W-1:0] rand_eps();
      logic [NUM_EPS-1:0][SYM_W-1:0] v;
      for (int i = 0; i < NUM_EPS; i++) begin
         v[i] = SYM_W'($urandom_range(2**SYM_W-1));
      end
      return v;
   endfunction

   // starts a job on the current falling edge and follows it to done,
   // or gives it up after abort_at enabled edges
   task automatic run_job(
      input logic [NUM_SYND-1:0][SYM_W-1:0] s,
      input logic [NUM_EPS-1:0][SYM_W-1:0]  e,
      input int                             stall_pct,   // chance of enable low
      input int                             abort_at     // 0 runs to done
   );
      logic [NUM_SYND-1:0][SYM_W-1:0] expect_val;
      logic [NUM_SYND-1:0][SYM_W-1:0] load_val;
      int                             n_en;
      int                             cycles;
      bit                             finished;
      expect_val  = trunc_product(s, e);
      if (e[NUM_EPS-1] != '0) begin
         load_val = s;                              // top coeff acts as a flag
      end
      else begin
         load_val = '0;
      end
      n_en        = 0;
      cycles      = 0;
      finished    = 1'b0;
      sync        = 1'b1;
      enable      = 1'b1;
      syndrome_in = s;
      epsilon_in  = e;
      while (!finished && cycles < JOB_LIMIT) begin
         @(posedge CLK);
         if (enable) begin
            n_en++;
         end
         @(negedge CLK);
         cycles++;
         sync        = 1'b0;
         syndrome_in = rand_synd();                 // ignored outside the load edge
         epsilon_in  = rand_eps();
         if (cycles == 1 && syndrome_out != load_val) begin
            errors++;
            $display("Error at %0t: accumulators after load are %h, expected %h",
                     $time, syndrome_out, load_val);
         end
         if (done) begin
            finished = 1'b1;
            if (abort_at != 0) begin
               errors++;
               $display("Error at %0t: done from a job that was restarted", $time);
            end
            else begin
               if (n_en != LATENCY) begin
                  errors++;
                  $display("Error at %0t: done after %0d enabled cycles, expected %0d",
                           $time, n_en, LATENCY);
               end
               for (int j = 0; j < NUM_SYND; j++) begin
                  if (syndrome_out[j] != expect_val[j]) begin
                     errors++;
                     $display("Error at %0t: syndrome_out[%0d] is %h, expected %h",
                              $time, j, syndrome_out[j], expect_val[j]);
                  end
               end
               last_expect = expect_val;
            end
         end
         else if (abort_at != 0 && n_en >= abort_at) begin
            finished = 1'b1;                        // next sync lands mid-job
         end
         else begin
            enable = ($urandom_range(99) >= stall_pct);
         end
      end
      if (!finished) begin
         errors++;
         $display("No done within %0d cycles of sync, job given up", JOB_LIMIT);
      end
   endtask

   // idle cycles after done, results must not move
   task automatic hold_check(input int idle_cycles);
      bit moved;
      moved = 1'b0;
      for (int c = 0; c < idle_cycles; c++) begin
         enable      = $urandom_range(1);
         sync        = 1'b0;
         syndrome_in = rand_synd();
         @(posedge CLK);
         if (enable) begin
            moved = 1'b1;
         end
         @(negedge CLK);
         if (syndrome_out != last_expect) begin
            errors++;
            $display("Error at %0t: syndrome_out changed while idle", $time);
         end
         if (moved && done) begin
            errors++;
            $display("Error at %0t: done held past one enabled cycle", $time);
         end
      end
   endtask

   // --------------------
   // test sequence
   // --------------------
   initial begin
      logic [NUM_SYND-1:0][SYM_W-1:0] s;
      logic [NUM_EPS-1:0][SYM_W-1:0]  e;
      void'($urandom(32'hdbc9));
      errors      = 0;
      CLK         = 1'b0;
      RESET       = 1'b0;
      enable      = 1'b0;
      sync        = 1'b0;
      syndrome_in = '0;
      epsilon_in  = '0;
      last_expect = '0;
      repeat (RESET_CYCLES) @(negedge CLK);
      RESET = 1'b1;

      repeat (3) begin                              // idle state after reset
         @(negedge CLK);
         if (done || syndrome_out != '0) begin
            errors++;
            $display("Error at %0t: outputs not cleared after reset", $time);
         end
      end

      for (int n = 0; n < NUM_RANDOM; n++) begin
         run_job(rand_synd(), rand_eps(), 0, 0);
         hold_check($urandom_range(8, 1));
      end

      // same operands, top coefficient zero then nonzero
      s = rand_synd();
      e = rand_eps();
      e[NUM_EPS-1] = '0;
      run_job(s, e, 0, 0);
      hold_check(2);
      e[NUM_EPS-1] = SYM_W'($urandom_range(2**SYM_W-1, 1));
      run_job(s, e, 0, 0);
      hold_check(2);

      for (int n = 0; n < NUM_STALL; n++) begin
         run_job(rand_synd(), rand_eps(), 40, 0);
         hold_check($urandom_range(8, 1));
      end

      for (int r = 0; r < NUM_RESTART; r++) begin
         run_job(rand_synd(), rand_eps(), 0, $urandom_range(18, 2));
         run_job(rand_synd(), rand_eps(), 25, 0);
         hold_check($urandom_range(8, 1));
      end

      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("sim passed");
      end
      else begin
         $display("sim failed");
      end
      $finish;
   end

   // --------------------
   // watchdog
   // --------------------
   initial begin
      #((RESET_CYCLES + TOTAL_JOBS * 60) * CLK_PERIOD);
      $display("Watchdog expired before the jobs finished, errors: %0d", errors);
      $display("sim failed");
      $finish;
   end

endmodule

// ==== verilog/epsilon_shifter.sv ====
// Erasure polynomial shifter
// Presents one epsilon coefficient per product row, highest first.
// The top coefficient goes straight through during the load cycle

module epsilon_shifter
   import rs_pkg::*;
(
   input  logic                            CLK,          // system clock
   input  logic                            RESET,        // async reset, active low
   input  logic                            load,         // take new epsilon
   input  logic                            step,         // advance one row
   input  logic [NUM_EPS-1:0][SYM_W-1:0]   epsilon_in,   // erasure polynomial
   output logic [SYM_W-1:0]                epsilon_msb   // coefficient for this row
);

   logic [NUM_EPS-1:0][SYM_W-1:0] eps_reg;          // top entry feeds the row

   // --------------------
   // shift register
   // --------------------
   // After load the top holds epsilon[19]; every step moves the next
   // lower coefficient up, ending with epsilon[0] on the 20th row.
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         eps_reg <= '0;
      end
      else if (load) begin
         eps_reg <= {epsilon_in[NUM_EPS-2:0], {SYM_W{1'b0}}};
      end
      else if (step) begin
         eps_reg <= {eps_reg[NUM_EPS-2:0], {SYM_W{1'b0}}};
      end
   end

   // --------------------
   // output select
   // --------------------
   always_comb begin
      if (load) begin
         epsilon_msb = epsilon_in[NUM_EPS-1];      // top coeff acts as a flag
      end
      else begin
         epsilon_msb = eps_reg[NUM_EPS-1];
      end
   end

   // load and step come from one decoder and must not overlap
   a_load_step_excl: assert property (
      @(posedge CLK) disable iff (!RESET)
      !(load && step)
   );

endmodule

// ==== verilog/gf_mult.sv ====
// GF(2^6) multiplier
// Purely combinational shift-and-add product of two field symbols,
// reduced on the fly by the field polynomial x^6+x+1

module gf_mult
   import rs_pkg::*;
(
   input  logic [SYM_W-1:0] a,                      // first factor
   input  logic [SYM_W-1:0] b,                      // second factor
   output logic [SYM_W-1:0] p                       // a times b in the field
);

   logic [SYM_W-1:0] acc;                           // running partial sum
   logic [SYM_W-1:0] a_shift;                       // a times x^i, reduced

   // --------------------
   // shift and add
   // --------------------
   // Each bit of b selects a times x^i. Multiplying by x is a left shift;
   // when the top bit falls out, x^6 is folded back in as GF_POLY.
   always_comb begin
      acc     = '0;
      a_shift = a;
      for (int i = 0; i < SYM_W; i++) begin
         if (b[i]) begin
            acc = acc ^ a_shift;                    // add this partial product
         end
         if (a_shift[SYM_W-1]) begin
            a_shift = {a_shift[SYM_W-2:0], 1'b0} ^ GF_POLY;  // reduce
         end
         else begin
            a_shift = {a_shift[SYM_W-2:0], 1'b0};
         end
      end
   end

   assign p = acc;

endmodule

// ==== verilog/polymul_ctrl.sv ====
// Polynomial multiplier sequencer
// Counts the 20 product rows of one job and decodes the load and step
// strobes for the datapath, plus the one cycle done strobe

module polymul_ctrl
   import rs_pkg::*;
(
   input  logic CLK,                                // system clock
   input  logic RESET,                              // async reset, active low
   input  logic enable,                             // global stall when low
   input  logic sync,                               // start or restart a job
   output logic load,                               // take new operands
   output logic step,                               // one product row
   output logic done                                // job finished
);

   logic [CNT_W-1:0] count;                         // 0 idle, 1..20 rows, 21 done

   // --------------------
   // strobes
   // --------------------
   assign load = enable && sync;
   assign step = enable && !sync && (count >= CNT_W'(1)) && (count < LAST_STEP);

   // held while stalled since count is frozen
   assign done = (count == LAST_STEP);

   // --------------------
   // step counter
   // --------------------
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         count <= '0;
      end
      else if (load) begin
         count <= CNT_W'(1);                        // restart also lands here
      end
      else if (enable) begin
         if (step) begin
            count <= count + CNT_W'(1);
         end
         else begin
            count <= '0;                            // idle, or leaving done
         end
      end
   end

   // done lasts a single enabled cycle
   a_done_single: assert property (
      @(posedge CLK) disable iff (!RESET)
      (done && enable && !sync) |=> !done
   );

endmodule

// ==== verilog/rs_pkg.sv ====
// Reed-Solomon polynomial multiplier constants
// GF(2^6) symbol format, polynomial sizes and the step counter range
// for the erasure times syndrome product stage

package rs_pkg;

   // --------------------
   // field
   // --------------------
   localparam int SYM_W = 6;                        // bits per GF(2^6) symbol

   // x^6 = x + 1, so only the low bits are kept
   localparam logic [SYM_W-1:0] GF_POLY = 6'b00_0011;

   // --------------------
   // polynomial sizes
   // --------------------
   localparam int NUM_SYND = 20;                    // syndrome and output symbols
   localparam int NUM_EPS  = 21;                    // erasure poly coefficients

   // --------------------
   // step counter
   // --------------------
   localparam int CNT_W = 5;                        // holds 0 .. LAST_STEP

   // count after the last product row, done is decoded here
   localparam logic [CNT_W-1:0] LAST_STEP = 5'd21;

endpackage

// ==== verilog/rs_polymul.sv ====
// Reed-Solomon erasure polynomial multiplier, GF(2^6)
// Returns the low 20 coefficients of epsilon(x) times S(x), one
// product row per enabled clock, with done 21 enabled cycles after sync

module rs_polymul
   import rs_pkg::*;
(
   input  logic                            CLK,           // system clock
   input  logic                            RESET,         // async reset, active low
   input  logic                            enable,        // global stall when low
   input  logic                            sync,          // start of job
   input  logic [NUM_SYND-1:0][SYM_W-1:0]  syndrome_in,   // syndrome polynomial
   input  logic [NUM_EPS-1:0][SYM_W-1:0]   epsilon_in,    // erasure polynomial
   output logic [NUM_SYND-1:0][SYM_W-1:0]  syndrome_out,  // modified syndromes
   output logic                            done           // one cycle completion
);

   logic             load;                          // operands taken this edge
   logic             step;                          // product row this edge
   logic [SYM_W-1:0] epsilon_msb;                   // row coefficient

   // --------------------
   // sequencer
   // --------------------
   polymul_ctrl u_ctrl (
      .CLK    (CLK),
      .RESET  (RESET),
      .enable (enable),
      .sync   (sync),
      .load   (load),
      .step   (step),
      .done   (done)
   );

   // --------------------
   // coefficient feed
   // --------------------
   epsilon_shifter u_eps (
      .CLK         (CLK),
      .RESET       (RESET),
      .load        (load),
      .step        (step),
      .epsilon_in  (epsilon_in),
      .epsilon_msb (epsilon_msb)
   );

   // --------------------
   // datapath
   // --------------------
   syndrome_mac u_mac (
      .CLK          (CLK),
      .RESET        (RESET),
      .load         (load),
      .step         (step),
      .syndrome_in  (syndrome_in),
      .epsilon_msb  (epsilon_msb),
      .syndrome_out (syndrome_out)
   );

endmodule

// ==== verilog/syndrome_mac.sv ====
// Syndrome multiply-accumulate array
// Stores the syndrome polynomial, multiplies every symbol by the current
// epsilon coefficient and folds the products into a shifting accumulator
// chain, Horner style, leaving the truncated product in the accumulators

module syndrome_mac
   import rs_pkg::*;
(
   input  logic                            CLK,           // system clock
   input  logic                            RESET,         // async reset, active low
   input  logic                            load,          // take new syndromes
   input  logic                            step,          // one product row
   input  logic [NUM_SYND-1:0][SYM_W-1:0]  syndrome_in,   // syndrome polynomial
   input  logic [SYM_W-1:0]                epsilon_msb,   // coefficient for this row
   output logic [NUM_SYND-1:0][SYM_W-1:0]  syndrome_out   // modified syndromes
);

   logic [NUM_SYND-1:0][SYM_W-1:0] synd_reg;        // stored S
   logic [NUM_SYND-1:0][SYM_W-1:0] product;         // epsilon_msb times S_i
   logic [NUM_SYND-1:0][SYM_W-1:0] acc;             // accumulator chain
   logic [NUM_SYND-1:0][SYM_W-1:0] acc_next;        // value after one row

   // --------------------
   // syndrome store
   // --------------------
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         synd_reg <= '0;
      end
      else if (load) begin
         synd_reg <= syndrome_in;
      end
   end

   // --------------------
   // multiplier row
   // --------------------
   for (genvar i = 0; i < NUM_SYND; i++) begin : g_mult
      gf_mult u_mult (
         .a (epsilon_msb),
         .b (synd_reg[i]),
         .p (product[i])
      );
   end

   // --------------------
   // accumulator chain
   // --------------------
   // Shifting the chain up one place multiplies the partial result by x;
   // whatever leaves the top is above x^19 and is dropped.
   assign acc_next = {acc[NUM_SYND-2:0], {SYM_W{1'b0}}} ^ product;

   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         acc <= '0;
      end
      else if (load) begin
         if (epsilon_msb != '0) begin
            acc <= syndrome_in;                     // epsilon[20] set, start at S
         end
         else begin
            acc <= '0;
         end
      end
      else if (step) begin
         acc <= acc_next;
      end
   end

   assign syndrome_out = acc;

   // row coefficient must be known whenever it is used
   a_eps_known: assert property (
      @(posedge CLK) disable iff (!RESET)
      (load || step) |-> !$isunknown(epsilon_msb)
   );

endmodule
